// File: hdl/sd_clk_gen.sv
module sd_clk_gen #(
    parameter int SLOW_HALF = 150,
    parameter int FAST_HALF = 2
) (
    input  logic              clk_fast,
    input  logic              rst,
    input  sd_pkg::sd_speed_t speed,
    output logic              sd_clk,
    output logic              tick_rise,
    output logic              tick_fall
);

    localparam int MAX_HALF = (SLOW_HALF > FAST_HALF) ? SLOW_HALF : FAST_HALF;
    localparam int CNT_W    = $clog2(MAX_HALF + 1);

    logic [CNT_W-1:0] half_cnt;
    logic [CNT_W-1:0] reload;
    logic             terminal;

    // Half period length for the current rate
    assign reload = (speed == sd_pkg::SPEED_FAST) ? CNT_W'(FAST_HALF - 1)
                                                  : CNT_W'(SLOW_HALF - 1);

    assign terminal = (speed != sd_pkg::SPEED_OFF) && (half_cnt == '0);

    always_ff @(posedge clk_fast) begin
        if (rst) begin
            half_cnt  <= '0;
            sd_clk    <= 1'b0;
            tick_rise <= 1'b0;
            tick_fall <= 1'b0;
        end else begin
            // Strobes line up with the sd_clk edge they announce
            tick_rise <= terminal && !sd_clk;
            tick_fall <= terminal && sd_clk;

            if (speed == sd_pkg::SPEED_OFF) begin
                // Counter frozen, clock parked low
                sd_clk <= 1'b0;
            end else if (terminal) begin
                half_cnt <= reload;
                sd_clk   <= ~sd_clk;
            end else begin
                half_cnt <= half_cnt - 1'b1;
            end
        end
    end

endmodule

// File: hdl/sd_cmd_top.sv
module sd_cmd_top #(
    parameter int SLOW_HALF = 150,
    parameter int FAST_HALF = 2
) (
    input  logic              clk_fast,
    input  logic              rst,
    // Host side
    input  sd_pkg::sd_speed_t speed,
    input  logic              cmd_start,
    input  sd_pkg::cmd_req_t  cmd_req,
    output logic              cmd_done,
    output logic              resp_done,
    output sd_pkg::resp_t     resp,
    output logic              resp_crc_err,
    output logic              busy,
    // Card side
    output logic              sd_clk,
    output logic              sd_cmd_out,
    output logic              sd_cmd_oe,
    input  logic              sd_cmd_in
);

    sd_pkg::sd_speed_t speed_q;
    sd_pkg::cmd_req_t  req;
    logic              tick_rise;
    logic              tick_fall;
    logic              tx_go;
    logic              tx_end;
    logic              rx_go;
    logic              rx_end;

    sd_clk_gen #(
        .SLOW_HALF (SLOW_HALF),
        .FAST_HALF (FAST_HALF)
    ) u_clk_gen (
        .clk_fast  (clk_fast),
        .rst       (rst),
        .speed     (speed_q),
        .sd_clk    (sd_clk),
        .tick_rise (tick_rise),
        .tick_fall (tick_fall)
    );

    sd_ctrl_regs u_regs (
        .clk_fast  (clk_fast),
        .rst       (rst),
        .speed_in  (speed),
        .cmd_start (cmd_start),
        .cmd_req   (cmd_req),
        .tx_end    (tx_end),
        .rx_end    (rx_end),
        .speed     (speed_q),
        .req       (req),
        .tx_go     (tx_go),
        .rx_go     (rx_go),
        .busy      (busy),
        .cmd_done  (cmd_done),
        .resp_done (resp_done)
    );

    sd_cmd_tx u_tx (
        .clk_fast   (clk_fast),
        .rst        (rst),
        .tick_fall  (tick_fall),
        .tx_go      (tx_go),
        .req        (req),
        .sd_cmd_out (sd_cmd_out),
        .sd_cmd_oe  (sd_cmd_oe),
        .tx_end     (tx_end)
    );

    sd_resp_rx u_rx (
        .clk_fast  (clk_fast),
        .rst       (rst),
        .tick_rise (tick_rise),
        .rx_go     (rx_go),
        .sd_cmd_in (sd_cmd_in),
        .resp      (resp),
        .crc_err   (resp_crc_err),
        .rx_end    (rx_end)
    );

endmodule

// File: hdl/sd_cmd_tx.sv
module sd_cmd_tx (
    input  logic             clk_fast,
    input  logic             rst,
    input  logic             tick_fall,
    input  logic             tx_go,
    input  sd_pkg::cmd_req_t req,
    output logic             sd_cmd_out,
    output logic             sd_cmd_oe,
    output logic             tx_end
);

    localparam int CNT_W  = $clog2(sd_pkg::FRAME_BITS + 1);
    localparam int BODY_W = sd_pkg::CONTENT_BITS;
    localparam int PAD_W  = BODY_W - sd_pkg::CRC_BITS + 1;

    logic                         active;
    logic [CNT_W-1:0]             bit_cnt;
    logic [BODY_W-1:0]            shreg;
    logic [sd_pkg::CRC_BITS-1:0]  crc;
    logic                         crc_en;
    logic                         at_crc;
    logic                         step;

    assign step   = tick_fall && active;
    assign at_crc = (bit_cnt == CNT_W'(sd_pkg::CONTENT_BITS));
    assign crc_en = step && (bit_cnt < CNT_W'(sd_pkg::CONTENT_BITS));

    sd_crc7 u_crc (
        .clk_fast (clk_fast),
        .rst      (rst),
        .clr      (tx_go),
        .en       (crc_en),
        .din      (shreg[BODY_W-1]),
        .crc      (crc)
    );

    // Frame body, then CRC tail with ones behind it for the end bit
    always_ff @(posedge clk_fast) begin
        if (tx_go) begin
            shreg <= {1'b0, 1'b1, req.index, req.arg};
        end else if (step) begin
            if (at_crc) begin
                shreg <= {crc[sd_pkg::CRC_BITS-2:0], {PAD_W{1'b1}}};
            end else begin
                shreg <= {shreg[BODY_W-2:0], 1'b1};
            end
        end
    end

    // ==============================
    // Line control
    // ==============================

    always_ff @(posedge clk_fast) begin
        if (rst) begin
            active     <= 1'b0;
            bit_cnt    <= '0;
            sd_cmd_out <= 1'b1;
            sd_cmd_oe  <= 1'b0;
            tx_end     <= 1'b0;
        end else begin
            tx_end <= 1'b0;
            if (tx_go) begin
                active  <= 1'b1;
                bit_cnt <= '0;
            end else if (step) begin
                if (bit_cnt == CNT_W'(sd_pkg::FRAME_BITS)) begin
                    // One falling edge past the end bit
                    active     <= 1'b0;
                    sd_cmd_oe  <= 1'b0;
                    sd_cmd_out <= 1'b1;
                    tx_end     <= 1'b1;
                end else begin
                    sd_cmd_oe  <= 1'b1;
                    sd_cmd_out <= at_crc ? crc[sd_pkg::CRC_BITS-1] : shreg[BODY_W-1];
                    bit_cnt    <= bit_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: hdl/sd_crc7.sv
module sd_crc7 (
    input  logic                        clk_fast,
    input  logic                        rst,
    input  logic                        clr,
    input  logic                        en,
    input  logic                        din,
    output logic [sd_pkg::CRC_BITS-1:0] crc
);

    logic feedback;

    // Polynomial x^7 + x^3 + 1, MSB first
    assign feedback = din ^ crc[sd_pkg::CRC_BITS-1];

    always_ff @(posedge clk_fast) begin
        if (rst) begin
            crc <= '0;
        end else if (clr) begin
            crc <= '0;
        end else if (en) begin
            crc[6] <= crc[5];
            crc[5] <= crc[4];
            crc[4] <= crc[3];
            crc[3] <= crc[2] ^ feedback;
            crc[2] <= crc[1];
            crc[1] <= crc[0];
            crc[0] <= feedback;
        end
    end

endmodule

// File: hdl/sd_ctrl_regs.sv
module sd_ctrl_regs (
    input  logic              clk_fast,
    input  logic              rst,
    input  sd_pkg::sd_speed_t speed_in,
    input  logic              cmd_start,
    input  sd_pkg::cmd_req_t  cmd_req,
    input  logic              tx_end,
    input  logic              rx_end,
    output sd_pkg::sd_speed_t speed,
    output sd_pkg::cmd_req_t  req,
    output logic              tx_go,
    output logic              rx_go,
    output logic              busy,
    output logic              cmd_done,
    output logic              resp_done
);

    logic accept;
    logic want_resp;

    // Requests while busy are dropped
    assign accept    = cmd_start && !busy;
    assign want_resp = (req.resp_type == sd_pkg::RESP_48);

    // ==============================
    // Configuration
    // ==============================

    // Rate only moves between commands
    always_ff @(posedge clk_fast) begin
        if (rst) begin
            speed <= sd_pkg::SPEED_OFF;
        end else if (!busy) begin
            speed <= speed_in;
        end
    end

    always_ff @(posedge clk_fast) begin
        if (accept) begin
            req <= cmd_req;
        end
    end

    // ==============================
    // Command sequencing
    // ==============================

    always_ff @(posedge clk_fast) begin
        if (rst) begin
            tx_go     <= 1'b0;
            rx_go     <= 1'b0;
            busy      <= 1'b0;
            cmd_done  <= 1'b0;
            resp_done <= 1'b0;
        end else begin
            tx_go     <= accept;
            cmd_done  <= tx_end;
            resp_done <= rx_end;

            // Receiver only armed when a response is expected
            rx_go <= tx_end && want_resp;

            if (accept) begin
                busy <= 1'b1;
            end else if ((tx_end && !want_resp) || rx_end) begin
                // Drops together with cmd_done or resp_done
                busy <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/sd_pkg.sv
package sd_pkg;

    // ==============================
    // Clock and response encodings
    // ==============================

    typedef enum logic [1:0] {
        SPEED_OFF  = 2'd0,
        SPEED_SLOW = 2'd1,
        SPEED_FAST = 2'd2
    } sd_speed_t;

    typedef enum logic {
        RESP_NONE = 1'b0,
        RESP_48   = 1'b1
    } resp_type_t;

    // ==============================
    // Host side records
    // ==============================

    // One command as the host requests it
    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] arg;
        resp_type_t  resp_type;
    } cmd_req_t;

    // Content of a short response without start and transmission bits
    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] arg;
    } resp_t;

    // ==============================
    // Frame geometry
    // ==============================

    localparam int FRAME_BITS      = 48;
    localparam int CONTENT_BITS    = 40;
    localparam int CRC_BITS        = 7;

    // Line turnaround after a command end bit
    localparam int RESP_GUARD_BITS = 2;

endpackage

// File: hdl/sd_resp_rx.sv
module sd_resp_rx (
    input  logic          clk_fast,
    input  logic          rst,
    input  logic          tick_rise,
    input  logic          rx_go,
    input  logic          sd_cmd_in,
    output sd_pkg::resp_t resp,
    output logic          crc_err,
    output logic          rx_end
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_GUARD,
        RX_HUNT,
        RX_SHIFT
    } rx_state_t;

    localparam int CNT_W   = $clog2(sd_pkg::FRAME_BITS + 1);
    localparam int GUARD_W = $clog2(sd_pkg::RESP_GUARD_BITS + 1);
    localparam int RESP_W  = $bits(sd_pkg::resp_t);

    rx_state_t                       state;
    logic [GUARD_W-1:0]              guard_cnt;
    logic [CNT_W-1:0]                bit_cnt;
    logic [sd_pkg::FRAME_BITS-1:0]   shreg;
    logic [sd_pkg::CRC_BITS-1:0]     crc;
    logic                            start_seen;
    logic                            sampling;
    logic                            crc_en;

    assign start_seen = tick_rise && (state == RX_HUNT) && !sd_cmd_in;
    assign sampling   = start_seen || (tick_rise && (state == RX_SHIFT));

    // CRC covers start bit through argument
    assign crc_en = start_seen ||
                    (tick_rise && (state == RX_SHIFT) &&
                     (bit_cnt < CNT_W'(sd_pkg::CONTENT_BITS)));

    sd_crc7 u_crc (
        .clk_fast (clk_fast),
        .rst      (rst),
        .clr      (rx_go),
        .en       (crc_en),
        .din      (sd_cmd_in),
        .crc      (crc)
    );

    always_ff @(posedge clk_fast) begin
        if (sampling) begin
            shreg <= {shreg[sd_pkg::FRAME_BITS-2:0], sd_cmd_in};
        end
    end

    // ==============================
    // Frame FSM
    // ==============================

    always_ff @(posedge clk_fast) begin
        if (rst) begin
            state     <= RX_IDLE;
            guard_cnt <= '0;
            bit_cnt   <= '0;
            rx_end    <= 1'b0;
        end else begin
            rx_end <= 1'b0;
            if (rx_go) begin
                state     <= RX_GUARD;
                guard_cnt <= '0;
            end else if (tick_rise) begin
                case (state)
                    RX_GUARD: begin
                        // Skip samples while the line turns around
                        if (guard_cnt == GUARD_W'(sd_pkg::RESP_GUARD_BITS - 1)) begin
                            state <= RX_HUNT;
                        end else begin
                            guard_cnt <= guard_cnt + 1'b1;
                        end
                    end
                    RX_HUNT: begin
                        if (!sd_cmd_in) begin
                            state   <= RX_SHIFT;
                            bit_cnt <= CNT_W'(1);
                        end
                    end
                    RX_SHIFT: begin
                        if (bit_cnt == CNT_W'(sd_pkg::FRAME_BITS - 1)) begin
                            state  <= RX_IDLE;
                            rx_end <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    default: begin
                        state <= RX_IDLE;
                    end
                endcase
            end
        end
    end

    // Results land on the cycle of resp_done
    always_ff @(posedge clk_fast) begin
        if (rx_end) begin
            resp <= shreg[sd_pkg::FRAME_BITS-3 -: RESP_W];
        end
    end

    always_ff @(posedge clk_fast) begin
        if (rst) begin
            crc_err <= 1'b0;
        end else if (rx_end) begin
            crc_err <= (shreg[sd_pkg::CRC_BITS:1] != crc) || !shreg[0];
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the command channel testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module sd_cmd_tb -o sd_cmd_sim \
    && ./obj_dir/sd_cmd_sim > sim.log 2>&1 ; cat sim.log 2>/dev/null

grep -q "Finished with no errors" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: sim/sd_cmd_asserts.sv
module sd_cmd_asserts (
    input logic              clk_fast,
    input logic              rst,
    input logic              busy,
    input logic              sd_cmd_oe,
    input logic              resp_done,
    input logic              sd_clk,
    input sd_pkg::sd_speed_t speed_q
);

    // Host only drives CMD inside a command
    assert property (@(posedge clk_fast) disable iff (rst)
        sd_cmd_oe |-> busy)
        else $error("sd_cmd_oe high while idle");

    // resp_done lands on the cycle busy drops
    assert property (@(posedge clk_fast) disable iff (rst)
        resp_done |-> $past(busy))
        else $error("resp_done outside a command");

    // ==============================
    // Clock parked while off
    // ==============================

    assert property (@(posedge clk_fast) disable iff (rst)
        (speed_q == sd_pkg::SPEED_OFF && $past(speed_q) == sd_pkg::SPEED_OFF)
        |=> $stable(sd_clk))
        else $error("sd_clk moved while speed is off");

endmodule

bind sd_cmd_top sd_cmd_asserts u_asserts (
    .clk_fast  (clk_fast),
    .rst       (rst),
    .busy      (busy),
    .sd_cmd_oe (sd_cmd_oe),
    .resp_done (resp_done),
    .sd_clk    (sd_clk),
    .speed_q   (speed_q)
);

// File: sim/sd_cmd_tb.sv
module sd_cmd_tb;

    localparam int SLOW_HALF = 6;
    localparam int FAST_HALF = 2;
    localparam int NUM_ROWS  = 6;
    localparam int WATCHDOG  = NUM_ROWS * 200 * 2 * SLOW_HALF * 40;

    typedef struct packed {
        sd_pkg::sd_speed_t  speed;
        logic [5:0]         index;
        logic [31:0]        arg;
        sd_pkg::resp_type_t resp_type;
        logic [3:0]         delay;
        logic [31:0]        resp_arg;
        logic               flip_crc;
        logic               flip_end;
        logic               dup_start;
    } row_t;

    logic              clk_fast;
    logic              rst;
    sd_pkg::sd_speed_t speed;
    logic              cmd_start;
    sd_pkg::cmd_req_t  cmd_req;
    logic              cmd_done;
    logic              resp_done;
    sd_pkg::resp_t     resp;
    logic              resp_crc_err;
    logic              busy;
    logic              sd_clk;
    logic              sd_cmd_out;
    logic              sd_cmd_oe;
    logic              sd_cmd_in;

    // Card side of the CMD line
    logic              card_oe;
    logic              card_out;
    logic              card_active;
    row_t              card_row;
    logic [47:0]       last_frame;
    int                frames_seen;

    row_t              rows [NUM_ROWS];
    int                row_cnt;
    logic [31:0]       lcg_state;
    int                errors;
    int                tests_failed;

    // Event monitor state
    int                cyc;
    int                last_rise;
    int                last_period;
    int                resp_done_cnt;
    logic              prev_busy;
    logic              prev_sd_clk;
    logic              fell_with_cmd;
    logic              fell_with_resp;
    sd_pkg::resp_t     resp_seen;
    logic              crc_err_seen;

    assign sd_cmd_in = sd_cmd_oe ? sd_cmd_out : (card_oe ? card_out : 1'b1);

    sd_cmd_top #(
        .SLOW_HALF (SLOW_HALF),
        .FAST_HALF (FAST_HALF)
    ) dut (
        .clk_fast     (clk_fast),
        .rst          (rst),
        .speed        (speed),
        .cmd_start    (cmd_start),
        .cmd_req      (cmd_req),
        .cmd_done     (cmd_done),
        .resp_done    (resp_done),
        .resp         (resp),
        .resp_crc_err (resp_crc_err),
        .busy         (busy),
        .sd_clk       (sd_clk),
        .sd_cmd_out   (sd_cmd_out),
        .sd_cmd_oe    (sd_cmd_oe),
        .sd_cmd_in    (sd_cmd_in)
    );

    initial begin
        clk_fast = 1'b0;
        forever begin
            #20 clk_fast = ~clk_fast;
        end
    end

    // ==============================
    // Reference models
    // ==============================

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Bitwise x^7 + x^3 + 1 with the first bit in as MSB
    function automatic logic [6:0] crc7_ref(input logic [39:0] bits);
        logic [6:0] c;
        logic       fb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = bits[i] ^ c[6];
            c = {c[5:0], 1'b0};
            if (fb) begin
                c = c ^ 7'h09;
            end
        end
        return c;
    endfunction

    task automatic check_frame(input logic [47:0] got, input logic [47:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(input sd_pkg::resp_t got, input sd_pkg::resp_t exp,
                              input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got index %0d arg %h expected index %0d arg %h",
                     $time, what, got.index, got.arg, exp.index, exp.arg);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic add_row(input sd_pkg::sd_speed_t spd, input logic [5:0] idx,
                           input logic [31:0] arg, input sd_pkg::resp_type_t rt,
                           input logic [3:0] dly, input logic fcrc, input logic fend,
                           input logic dup);
        row_t r;
        lcg_state = lcg_next(lcg_state);
        r.speed     = spd;
        r.index     = idx;
        r.arg       = arg;
        r.resp_type = rt;
        r.delay     = dly;
        r.resp_arg  = lcg_state;
        r.flip_crc  = fcrc;
        r.flip_end  = fend;
        r.dup_start = dup;
        rows[row_cnt] = r;
        row_cnt++;
    endtask

    // ==============================
    // Card model
    // ==============================

    initial begin
        logic [47:0] cap;
        logic [39:0] content;
        logic [6:0]  crc;
        logic [47:0] rframe;
        card_oe     = 1'b0;
        card_out    = 1'b1;
        card_active = 1'b0;
        frames_seen = 0;
        forever begin
            @(posedge sd_clk);
            if (sd_cmd_oe) begin
                card_active = 1'b1;
                cap[47] = sd_cmd_out;
                for (int i = 46; i >= 0; i--) begin
                    @(posedge sd_clk);
                    cap[i] = sd_cmd_out;
                end
                last_frame = cap;
                frames_seen++;
                if (card_row.resp_type == sd_pkg::RESP_48) begin
                    content = {2'b00, cap[45:40], card_row.resp_arg};
                    crc = crc7_ref(content);
                    crc[0] = crc[0] ^ card_row.flip_crc;
                    rframe = {content, crc, ~card_row.flip_end};
                    repeat (int'(card_row.delay) + 2) @(negedge sd_clk);
                    for (int i = 47; i >= 0; i--) begin
                        if (i != 47) begin
                            @(negedge sd_clk);
                        end
                        card_oe  <= 1'b1;
                        card_out <= rframe[i];
                    end
                    @(negedge sd_clk);
                    card_oe  <= 1'b0;
                    card_out <= 1'b1;
                end
                card_active = 1'b0;
            end
        end
    end

    // Sample half a cycle after the DUT registers move
    always @(negedge clk_fast) begin
        cyc <= cyc + 1;
        prev_busy   <= busy;
        prev_sd_clk <= sd_clk;
        if (sd_clk && !prev_sd_clk) begin
            last_period <= cyc - last_rise;
            last_rise   <= cyc;
        end
        if (resp_done) begin
            resp_done_cnt <= resp_done_cnt + 1;
            resp_seen     <= resp;
            crc_err_seen  <= resp_crc_err;
        end
        if (prev_busy && !busy) begin
            fell_with_cmd  <= cmd_done;
            fell_with_resp <= resp_done;
        end
    end

    initial begin
        #(WATCHDOG);
        $display("Timeout: the tests did not complete in the allowed time");
        $display("Finished with errors");
        $finish;
    end

    // ==============================
    // Stimulus loop
    // ==============================

    initial begin
        row_t             r;
        sd_pkg::cmd_req_t req_v;
        sd_pkg::resp_t    exp_resp;
        sd_pkg::resp_t    resp_hold;
        logic             crc_err_hold;
        logic [47:0]      exp_frame;
        int               err_before;
        int               half;
        rst = 1'b1;
        speed = sd_pkg::SPEED_OFF;
        cmd_start = 1'b0;
        cmd_req = '0;
        card_row = '0;
        cyc = 0;
        last_rise = 0;
        last_period = 0;
        resp_done_cnt = 0;
        prev_busy = 1'b0;
        prev_sd_clk = 1'b0;
        errors = 0;
        tests_failed = 0;
        row_cnt = 0;
        lcg_state = 32'ha80f8f93;

        add_row(sd_pkg::SPEED_SLOW, 6'd0,  32'h00000000, sd_pkg::RESP_NONE, 4'd2, 0, 0, 0);
        add_row(sd_pkg::SPEED_FAST, 6'd8,  32'h000001aa, sd_pkg::RESP_48,   4'd2, 0, 0, 0);
        add_row(sd_pkg::SPEED_SLOW, 6'd55, 32'h00000000, sd_pkg::RESP_48,   4'd5, 0, 0, 1);
        add_row(sd_pkg::SPEED_FAST, 6'd41, 32'h40ff8000, sd_pkg::RESP_48,   4'd8, 1, 0, 0);
        add_row(sd_pkg::SPEED_FAST, 6'd2,  32'h12345678, sd_pkg::RESP_48,   4'd3, 0, 1, 1);
        add_row(sd_pkg::SPEED_SLOW, 6'd7,  32'hdeadbeef, sd_pkg::RESP_NONE, 4'd4, 0, 0, 1);

        repeat (2) @(posedge clk_fast);
        rst <= 1'b0;

        for (int t = 0; t < NUM_ROWS; t++) begin
            r = rows[t];
            err_before = errors;
            // Results of the previous response must survive a command without one
            resp_hold = resp;
            crc_err_hold = resp_crc_err;
            @(posedge clk_fast);
            speed <= r.speed;
            repeat (3) @(posedge clk_fast);
            card_row = r;
            frames_seen = 0;
            resp_done_cnt <= 0;
            req_v.index = r.index;
            req_v.arg = r.arg;
            req_v.resp_type = r.resp_type;
            cmd_start <= 1'b1;
            cmd_req <= req_v;
            @(posedge clk_fast);
            cmd_start <= 1'b0;
            while (!busy) @(negedge clk_fast);
            if (r.dup_start) begin
                // Must be dropped by the DUT
                repeat (3) @(posedge clk_fast);
                req_v.index = ~r.index;
                req_v.arg = ~r.arg;
                cmd_start <= 1'b1;
                cmd_req <= req_v;
                @(posedge clk_fast);
                cmd_start <= 1'b0;
            end
            while (busy) @(negedge clk_fast);
            while (card_active) @(negedge clk_fast);
            @(negedge clk_fast);

            exp_frame = {2'b01, r.index, r.arg, crc7_ref({2'b01, r.index, r.arg}), 1'b1};
            check_flag(frames_seen == 1, 1'b1, "exactly one command frame");
            check_frame(last_frame, exp_frame, "command frame");
            if (r.resp_type == sd_pkg::RESP_48) begin
                exp_resp.index = r.index;
                exp_resp.arg = r.resp_arg;
                check_flag(resp_done_cnt == 1, 1'b1, "one resp_done");
                check_resp(resp_seen, exp_resp, "response content");
                check_flag(crc_err_seen, r.flip_crc | r.flip_end, "resp_crc_err");
                check_flag(fell_with_resp, 1'b1, "busy falls with resp_done");
            end else begin
                check_flag(resp_done_cnt == 0, 1'b1, "no resp_done");
                check_flag(fell_with_cmd, 1'b1, "busy falls with cmd_done");
                check_resp(resp, resp_hold, "resp holds without a response");
                check_flag(resp_crc_err, crc_err_hold, "resp_crc_err holds without a response");
            end
            half = (r.speed == sd_pkg::SPEED_FAST) ? FAST_HALF : SLOW_HALF;
            check_flag(last_period == 2 * half, 1'b1, "sd_clk period");

            if (errors != err_before) begin
                tests_failed++;
                $display("test %0d index %0d: failed", t, r.index);
            end else begin
                $display("test %0d index %0d: passed", t, r.index);
            end
        end

        $display("%0d tests passed, %0d tests failed, %0d check errors",
                 NUM_ROWS - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: src.f
hdl/sd_pkg.sv
hdl/sd_crc7.sv
hdl/sd_clk_gen.sv
hdl/sd_ctrl_regs.sv
hdl/sd_cmd_tx.sv
hdl/sd_resp_rx.sv
hdl/sd_cmd_top.sv
sim/sd_cmd_asserts.sv
sim/sd_cmd_tb.sv
